// File: logic/core_pkg.sv
package core_pkg;

    // data and address width of the core
    localparam int xlen = 32;

    // register index width, which gives 32 architectural registers
    localparam int reg_addr_w = 5;

    // source of the value written back to the integer register file
    // code 101 has no source and falls back to the ALU result in write-back
    typedef enum logic [2:0] {
        res_alu = 3'b000,
        res_mem = 3'b001,
        res_pc4 = 3'b010,
        res_csr = 3'b011,
        res_imm = 3'b100,
        res_fpu = 3'b110,
        res_in  = 3'b111
    } result_src_e;

    // control bundle handed over by the memory stage
    // the FPU file reuses result_src, where res_mem picks the load data
    // and every other code picks the FPU unit result
    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        fpu_reg_write;
        result_src_e result_src;
    } ctrl_mem_t;

    // data bundle handed over by the memory stage
    // rd is shared by the integer and the FPU destination
    typedef struct packed {
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       read_data;
        logic [xlen-1:0]       pc_plus4;
        logic [xlen-1:0]       csr_data;
        logic [xlen-1:0]       imm_ext;
        logic [reg_addr_w-1:0] rd;
    } data_mem_t;

    // one register file write, as driven by write-back into a register file
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } wb_write_t;

endpackage

// File: logic/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                clk,
    input  logic                rst,

    // from the memory stage
    input  core_pkg::ctrl_mem_t ctrl_in,
    input  core_pkg::data_mem_t data_in,

    // to the write-back stage
    output core_pkg::ctrl_mem_t ctrl_out,
    output core_pkg::data_mem_t data_out
);
    import core_pkg::*;

    // control bundle with both write enables already qualified by valid
    ctrl_mem_t ctrl_gated;

    // a bubble must never write, so the enables are folded with valid here
    // and write-back only has to look at reg_write and fpu_reg_write
    always_comb begin
        ctrl_gated               = ctrl_in;
        ctrl_gated.reg_write     = ctrl_in.valid & ctrl_in.reg_write;
        ctrl_gated.fpu_reg_write = ctrl_in.valid & ctrl_in.fpu_reg_write;
    end

    // control half of the pipeline register
    // clearing it on reset is enough to keep both register files untouched
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_out <= '0;
        end else begin
            ctrl_out <= ctrl_gated;
        end
    end

    // data half of the pipeline register, captured every cycle
    // its content only matters when the control half asks for a write
    always_ff @(posedge clk) begin
        data_out <= data_in;
    end

endmodule

// File: logic/write_back.sv
`timescale 1ns/1ps

module write_back (
    input  logic                      clk,
    input  logic                      rst,

    // from the mem/wb pipeline register
    input  core_pkg::ctrl_mem_t       ctrl,
    input  core_pkg::data_mem_t       data,

    // from the FPU unit and the input port
    input  logic [core_pkg::xlen-1:0] fpu_result,
    input  logic [core_pkg::xlen-1:0] in_data,

    // from the fetch and execute stages
    input  logic [core_pkg::xlen-1:0] pc_plus4_f,
    input  logic [core_pkg::xlen-1:0] pc_target_e,
    input  logic                      pc_src_e,
    input  logic                      stall_f,

    // to the register files
    output core_pkg::wb_write_t       int_wr,
    output core_pkg::wb_write_t       fpu_wr,

    // to instruction memory and the fetch stage
    output logic [core_pkg::xlen-1:0] instr_addr,
    output logic [core_pkg::xlen-1:0] pc_f
);
    import core_pkg::*;

    logic [xlen-1:0] int_result;
    logic [xlen-1:0] fpu_wb_result;

    // integer result selection
    // in_data is taken live; the input transfer is expected to be over
    // by the time the "in" instruction gets here, so no extra wait is needed
    always_comb begin
        case (ctrl.result_src)
            res_alu: int_result = data.alu_result;
            res_mem: int_result = data.read_data;
            res_pc4: int_result = data.pc_plus4;
            res_csr: int_result = data.csr_data;
            res_imm: int_result = data.imm_ext;
            res_fpu: int_result = fpu_result;
            res_in:  int_result = in_data;
            // unused code 101 keeps a known value on the write data
            default: int_result = data.alu_result;
        endcase
    end

    // FPU result selection, only a load goes to the FPU file from memory
    always_comb begin
        if (ctrl.result_src == res_mem) begin
            fpu_wb_result = data.read_data;
        end else begin
            fpu_wb_result = fpu_result;
        end
    end

    // both write buses share the destination index of the bundle
    // the enables were qualified by valid in the pipeline register
    assign int_wr.we   = ctrl.reg_write;
    assign int_wr.addr = data.rd;
    assign int_wr.data = int_result;

    assign fpu_wr.we   = ctrl.fpu_reg_write;
    assign fpu_wr.addr = data.rd;
    assign fpu_wr.data = fpu_wb_result;

    // next fetch address goes straight to instruction memory
    assign instr_addr = pc_src_e ? pc_target_e : pc_plus4_f;

    // fetch-address register, frozen while fetch is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_f <= '0;
        end else if (!stall_f) begin
            pc_f <= instr_addr;
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    // 1 makes entry 0 a constant zero, as for the integer file
    parameter bit has_zero_reg = 1'b1
) (
    input  logic                            clk,
    input  logic                            rst,

    // write port from write-back
    input  core_pkg::wb_write_t             wr,

    // read ports to the decode stage
    input  logic [core_pkg::reg_addr_w-1:0] ra1,
    input  logic [core_pkg::reg_addr_w-1:0] ra2,
    output logic [core_pkg::xlen-1:0]       rd1,
    output logic [core_pkg::xlen-1:0]       rd2
);
    import core_pkg::*;

    localparam int depth = 1 << reg_addr_w;

    logic [xlen-1:0] regs [depth];

    // a write to entry 0 is dropped when that entry is hard-wired
    logic wr_en;

    assign wr_en = wr.we && !(has_zero_reg && (wr.addr == '0));

    // all entries start from zero after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // asynchronous reads without bypass
    // a value written at an edge shows up on the read ports after that edge
    always_comb begin
        if (has_zero_reg && (ra1 == '0)) begin
            rd1 = '0;
        end else begin
            rd1 = regs[ra1];
        end
    end

    always_comb begin
        if (has_zero_reg && (ra2 == '0)) begin
            rd2 = '0;
        end else begin
            rd2 = regs[ra2];
        end
    end

endmodule

// File: logic/in_port.sv
`timescale 1ns/1ps

module in_port (
    input  logic                      clk,
    input  logic                      rst,

    // from the decode stage, one cycle per "in" instruction
    input  logic                      in_issued,

    // device side of the four-phase handshake
    input  logic                      dev_ack,
    input  logic [core_pkg::xlen-1:0] dev_data,
    output logic                      dev_req,

    // to the surroundings and to write-back
    output logic                      in_busy,
    output logic [core_pkg::xlen-1:0] in_data
);
    // idle waits for an issue, request keeps dev_req up until the ack,
    // release waits for the device to drop its ack
    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_release
    } state_e;

    state_e state;
    state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                // an issue during a transfer cannot happen here since
                // only the idle state listens to in_issued
                if (in_issued) begin
                    state_next = st_request;
                end
            end
            st_request: begin
                if (dev_ack) begin
                    state_next = st_release;
                end
            end
            st_release: begin
                if (!dev_ack) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // the word is taken on the first cycle the ack is seen
    // and stays on in_data until the next transfer replaces it
    always_ff @(posedge clk) begin
        if ((state == st_request) && dev_ack) begin
            in_data <= dev_data;
        end
    end

    // request is up only while waiting for the ack, so it falls right after
    assign dev_req = (state == st_request);

    // busy covers the whole transfer, from the cycle after the issue
    assign in_busy = (state != st_idle);

endmodule

// File: logic/wb_top.sv
`timescale 1ns/1ps

module wb_top #(
    parameter bit int_zero_reg = 1'b1,
    parameter bit fpu_zero_reg = 1'b0
) (
    input  logic                            clk,
    input  logic                            rst,

    // from the memory stage
    input  core_pkg::ctrl_mem_t             ctrl_mem,
    input  core_pkg::data_mem_t             data_mem,

    // from the FPU unit
    input  logic [core_pkg::xlen-1:0]       fpu_result,

    // from the fetch and execute stages
    input  logic [core_pkg::xlen-1:0]       pc_plus4_f,
    input  logic [core_pkg::xlen-1:0]       pc_target_e,
    input  logic                            pc_src_e,
    input  logic                            stall_f,

    // input device and its handshake
    input  logic                            in_issued,
    input  logic                            dev_ack,
    input  logic [core_pkg::xlen-1:0]       dev_data,
    output logic                            dev_req,
    output logic                            in_busy,

    // to instruction memory and the fetch stage
    output logic [core_pkg::xlen-1:0]       instr_addr,
    output logic [core_pkg::xlen-1:0]       pc_f,

    // register file read ports toward decode
    input  logic [core_pkg::reg_addr_w-1:0] int_ra1,
    input  logic [core_pkg::reg_addr_w-1:0] int_ra2,
    input  logic [core_pkg::reg_addr_w-1:0] fpu_ra1,
    input  logic [core_pkg::reg_addr_w-1:0] fpu_ra2,
    output logic [core_pkg::xlen-1:0]       int_rd1,
    output logic [core_pkg::xlen-1:0]       int_rd2,
    output logic [core_pkg::xlen-1:0]       fpu_rd1,
    output logic [core_pkg::xlen-1:0]       fpu_rd2
);
    import core_pkg::*;

    // bundles as seen by the write-back stage
    ctrl_mem_t       ctrl_wb;
    data_mem_t       data_wb;

    // write buses into the two register files
    wb_write_t       int_wr;
    wb_write_t       fpu_wr;

    // word fetched by the input port
    logic [xlen-1:0] in_data;

    mem_wb_reg mwr (
        .clk     (clk),
        .rst     (rst),
        .ctrl_in (ctrl_mem),
        .data_in (data_mem),
        .ctrl_out(ctrl_wb),
        .data_out(data_wb)
    );

    write_back wb (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl_wb),
        .data       (data_wb),
        .fpu_result (fpu_result),
        .in_data    (in_data),
        .pc_plus4_f (pc_plus4_f),
        .pc_target_e(pc_target_e),
        .pc_src_e   (pc_src_e),
        .stall_f    (stall_f),
        .int_wr     (int_wr),
        .fpu_wr     (fpu_wr),
        .instr_addr (instr_addr),
        .pc_f       (pc_f)
    );

    // integer file with x0 tied to zero
    reg_file #(.has_zero_reg(int_zero_reg)) int_rf (
        .clk(clk),
        .rst(rst),
        .wr (int_wr),
        .ra1(int_ra1),
        .ra2(int_ra2),
        .rd1(int_rd1),
        .rd2(int_rd2)
    );

    // FPU file, where f0 is an ordinary register
    reg_file #(.has_zero_reg(fpu_zero_reg)) fpu_rf (
        .clk(clk),
        .rst(rst),
        .wr (fpu_wr),
        .ra1(fpu_ra1),
        .ra2(fpu_ra2),
        .rd1(fpu_rd1),
        .rd2(fpu_rd2)
    );

    in_port inp (
        .clk      (clk),
        .rst      (rst),
        .in_issued(in_issued),
        .dev_ack  (dev_ack),
        .dev_data (dev_data),
        .dev_req  (dev_req),
        .in_busy  (in_busy),
        .in_data  (in_data)
    );

endmodule

// File: verification/wb_chk.sv
`timescale 1ns/1ps

module wb_chk (
    input logic clk,
    input logic rst,
    input logic in_issued,
    input logic in_busy,
    input logic dev_req,
    input logic dev_ack,
    input logic valid,
    input logic int_we,
    input logic fpu_we
);
    int fail_count = 0;

    // a request may only be withdrawn after the device has acknowledged it
    req_until_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(dev_req) |-> $past(dev_ack))
        else begin
            fail_count++;
            $error("dev_req fell before dev_ack rose");
        end

    // a new "in" instruction must wait until the previous transfer is over
    issue_when_idle: assert property (@(posedge clk) disable iff (rst)
        in_issued |-> !in_busy)
        else begin
            fail_count++;
            $error("in_issued pulsed while in_busy was high");
        end

    // a bubble in write-back never reaches a register file
    no_write_on_bubble: assert property (@(posedge clk) disable iff (rst)
        !valid |-> !(int_we || fpu_we))
        else begin
            fail_count++;
            $error("write enable high while the write-back bundle was not valid");
        end

endmodule

// the top level holds both the in_port handshake and the write-back enables
bind wb_top wb_chk wb_chk_i (
    .clk      (clk),
    .rst      (rst),
    .in_issued(in_issued),
    .in_busy  (in_busy),
    .dev_req  (dev_req),
    .dev_ack  (dev_ack),
    .valid    (ctrl_wb.valid),
    .int_we   (int_wr.we),
    .fpu_we   (fpu_wr.we)
);

// File: verification/wb_scoreboard.sv
`timescale 1ns/1ps

module wb_scoreboard (
    input  logic                                 clk,
    input  logic                                 rst,

    // stimulus as the DUT samples it
    input  core_pkg::ctrl_mem_t                  ctrl_mem,
    input  core_pkg::data_mem_t                  data_mem,
    input  logic [core_pkg::xlen-1:0]            fpu_result,
    input  logic [core_pkg::xlen-1:0]            pc_plus4_f,
    input  logic [core_pkg::xlen-1:0]            pc_target_e,
    input  logic                                 pc_src_e,
    input  logic                                 stall_f,
    input  logic                                 in_issued,
    input  logic                                 dev_ack,
    input  logic [core_pkg::xlen-1:0]            dev_data,

    // read ports in the order int_ra1, int_ra2, fpu_ra1, fpu_ra2
    input  logic [3:0][core_pkg::reg_addr_w-1:0] ra,
    input  logic [3:0][core_pkg::xlen-1:0]       rd,
    input  logic [core_pkg::xlen-1:0]            instr_addr,
    input  logic [core_pkg::xlen-1:0]            pc_f,

    // input port handshake outputs
    input  logic                                 dev_req,
    input  logic                                 in_busy,

    output int                                   err_count,
    output int                                   check_count
);
    import core_pkg::*;

    logic [xlen-1:0] int_model [32];
    logic [xlen-1:0] fpu_model [32];
    // the bundle that sits in the mem/wb register
    ctrl_mem_t       stage_ctrl;
    data_mem_t       stage_data;
    logic [xlen-1:0] pc_model;
    logic [xlen-1:0] in_model;
    // expected handshake outputs of the input port
    logic            req_model;
    logic            busy_model;
    bit              armed = 1'b0;
    logic [xlen-1:0] expected;
    string           port_names [4] = '{"int_rd1", "int_rd2", "fpu_rd1", "fpu_rd2"};

    initial begin
        err_count   = 0;
        check_count = 0;
    end

    // integer write value by result source, where the unused code gives the ALU result
    function automatic logic [xlen-1:0] int_value(ctrl_mem_t c, data_mem_t d);
        case (c.result_src)
            res_mem: return d.read_data;
            res_pc4: return d.pc_plus4;
            res_csr: return d.csr_data;
            res_imm: return d.imm_ext;
            res_fpu: return fpu_result;
            res_in:  return in_model;
            default: return d.alu_result;
        endcase
    endfunction

    task automatic compare_word(string name, logic [xlen-1:0] exp, logic [xlen-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] time %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_bit(string name, logic exp, logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] time %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                int_model[i] = '0;
                fpu_model[i] = '0;
            end
            stage_ctrl = '0;
            pc_model   = '0;
            req_model  = 1'b0;
            busy_model = 1'b0;
            armed      = 1'b1;
        end else begin
            // the bundle taken one edge ago is written at this edge, and x0 stays zero
            if (stage_ctrl.valid && stage_ctrl.reg_write && stage_data.rd != 0) begin
                int_model[stage_data.rd] = int_value(stage_ctrl, stage_data);
            end
            // only a load sends memory data to the FPU file
            if (stage_ctrl.valid && stage_ctrl.fpu_reg_write) begin
                fpu_model[stage_data.rd] = (stage_ctrl.result_src == res_mem) ?
                                           stage_data.read_data : fpu_result;
            end
            stage_ctrl = ctrl_mem;
            stage_data = data_mem;
            if (!stall_f) begin
                pc_model = pc_src_e ? pc_target_e : pc_plus4_f;
            end
            // an issue raises the request, the first ack takes the word and drops it,
            // and the transfer is over once the ack is gone again
            if (!busy_model) begin
                if (in_issued) begin
                    busy_model = 1'b1;
                    req_model  = 1'b1;
                end
            end else if (req_model) begin
                if (dev_ack) begin
                    req_model = 1'b0;
                    in_model  = dev_data;
                end
            end else if (!dev_ack) begin
                busy_model = 1'b0;
            end
        end
    end

    // everything is compared mid-cycle, when the read addresses and the files are settled
    always @(negedge clk) begin
        if (armed) begin
            for (int p = 0; p < 4; p++) begin
                if (p < 2) begin
                    expected = (ra[p] == 0) ? '0 : int_model[ra[p]];
                end else begin
                    expected = fpu_model[ra[p]];
                end
                compare_word(port_names[p], expected, rd[p]);
            end
            compare_word("instr_addr", pc_src_e ? pc_target_e : pc_plus4_f, instr_addr);
            compare_word("pc_f", pc_model, pc_f);
            compare_bit("dev_req", req_model, dev_req);
            compare_bit("in_busy", busy_model, in_busy);
        end
    end

endmodule

// File: verification/wb_tb.sv
`timescale 1ns/1ps

module wb_tb;
    import core_pkg::*;

    localparam int n_writes = 200;
    localparam int n_in = 24;
    localparam int n_pc = 300;
    // three write tests with sweeps, the input transfers and the fetch test come to
    // about 1300 cycles, so this leaves room for slow acks
    localparam int max_cycles = 6000;

    logic                       clk;
    logic                       rst;
    ctrl_mem_t                  ctrl_mem;
    data_mem_t                  data_mem;
    logic [xlen-1:0]            fpu_result;
    logic [xlen-1:0]            pc_plus4_f;
    logic [xlen-1:0]            pc_target_e;
    logic                       pc_src_e;
    logic                       stall_f;
    logic                       in_issued;
    logic                       dev_ack;
    logic [xlen-1:0]            dev_data;
    logic                       dev_req;
    logic                       in_busy;
    logic [xlen-1:0]            instr_addr;
    logic [xlen-1:0]            pc_f;
    logic [3:0][reg_addr_w-1:0] ra;
    logic [3:0][xlen-1:0]       rd;
    int                         err_count;
    int                         check_count;
    int                         seed = 32'hb538;
    int                         cycles = 0;
    int                         tests_run = 0;
    int                         tests_clean = 0;
    int                         last_errors = 0;
    result_src_e                src_codes [7] = '{res_alu, res_mem, res_pc4, res_csr,
                                                 res_imm, res_fpu, res_in};

    wb_top wb_top_i (
        .*,
        .int_ra1(ra[0]),
        .int_ra2(ra[1]),
        .fpu_ra1(ra[2]),
        .fpu_ra2(ra[3]),
        .int_rd1(rd[0]),
        .int_rd2(rd[1]),
        .fpu_rd1(rd[2]),
        .fpu_rd2(rd[3])
    );

    wb_scoreboard sb_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int total_errors();
        return err_count + wb_top_i.wb_chk_i.fail_count;
    endfunction

    // mostly valid bundles with a random source and random enables
    function automatic ctrl_mem_t random_ctrl(input bit allow_int, input bit allow_fpu);
        ctrl_mem_t c;
        c.valid         = ($random(seed) & 7) != 0;
        c.reg_write     = allow_int & $random(seed);
        c.fpu_reg_write = allow_fpu & $random(seed);
        c.result_src    = src_codes[$unsigned($random(seed)) % 7];
        return c;
    endfunction

    // one cycle of stimulus, with fresh bundle data and fetch-side inputs
    task automatic drive_cycle(input ctrl_mem_t c, input logic [reg_addr_w-1:0] dst);
        data_mem_t d;
        d = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed), dst};
        @(posedge clk);
        ctrl_mem    <= c;
        data_mem    <= d;
        fpu_result  <= $random(seed);
        pc_plus4_f  <= $random(seed);
        pc_target_e <= $random(seed);
        pc_src_e    <= $random(seed);
        stall_f     <= $random(seed);
    endtask

    // bubbles while every index passes over all four read ports
    task automatic sweep_reads();
        logic [reg_addr_w-1:0] idx;
        for (int i = 0; i < 34; i++) begin
            idx = i % 32;
            drive_cycle('0, '0);
            ra <= {~idx, idx, ~idx, idx};
        end
    endtask

    task automatic in_transfer();
        @(posedge clk);
        in_issued <= 1'b1;
        @(posedge clk);
        in_issued <= 1'b0;
        // in_busy only shows up one edge after the issue is seen
        do begin
            @(posedge clk);
        end while (in_busy);
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = total_errors() - last_errors;
        last_errors += errs;
        tests_run++;
        if (errs == 0) begin
            tests_clean++;
        end
        $display("test %0d (%s): %0d errors, %0d checks so far", tests_run, name, errs,
                 check_count);
    endtask

    // device side: ack after 0 to 3 cycles, drop it once the request is gone
    initial begin : device
        int delay;
        dev_ack  = 1'b0;
        dev_data = '0;
        forever begin
            @(posedge clk);
            if (dev_req === 1'b1) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                dev_ack  <= 1'b1;
                dev_data <= $random(seed);
                do begin
                    @(posedge clk);
                end while (dev_req === 1'b1);
                dev_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        ctrl_mem_t             c;
        logic [reg_addr_w-1:0] dst;
        rst         = 1'b1;
        ctrl_mem    = '0;
        data_mem    = '0;
        fpu_result  = '0;
        pc_plus4_f  = '0;
        pc_target_e = '0;
        pc_src_e    = 1'b0;
        stall_f     = 1'b0;
        in_issued   = 1'b0;
        ra          = '0;
        apply_reset();
        // one transfer up front so that in_data holds a known word
        drive_cycle('0, '0);
        in_transfer();

        // integer writes over the seven sources, bubbles included
        for (int i = 0; i < n_writes; i++) begin
            dst = $random(seed);
            drive_cycle(random_ctrl(1'b1, 1'b0), dst);
        end
        sweep_reads();
        report_test("integer result select");

        // FPU writes, every fourth one to f0
        for (int i = 0; i < n_writes; i++) begin
            dst = (i % 4 == 0) ? '0 : $random(seed);
            drive_cycle(random_ctrl(1'b0, 1'b1), dst);
        end
        sweep_reads();
        report_test("fpu write path");

        // pairs of writes to the same index, half of them to x0
        for (int i = 0; i < n_writes / 2; i++) begin
            dst = (i % 2 == 0) ? '0 : $random(seed);
            repeat (2) begin
                c           = random_ctrl(1'b1, 1'b1);
                c.valid     = 1'b1;
                c.reg_write = 1'b1;
                drive_cycle(c, dst);
            end
        end
        sweep_reads();
        report_test("x0 and back-to-back writes");

        // each transfer is followed by an "in" bundle and then a bubble
        for (int i = 0; i < n_in; i++) begin
            in_transfer();
            c            = random_ctrl(1'b1, 1'b1);
            c.valid      = 1'b1;
            c.reg_write  = 1'b1;
            c.result_src = res_in;
            dst          = i % 31 + 1;
            drive_cycle(c, dst);
            drive_cycle('0, '0);
        end
        sweep_reads();
        report_test("input port");

        // fetch address from a fresh reset under random redirects and stalls
        apply_reset();
        repeat (n_pc) drive_cycle('0, '0);
        report_test("fetch address");

        $display("tests run %0d, clean %0d, checks %0d, errors %0d", tests_run, tests_clean,
                 check_count, total_errors());
        if (total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/core_pkg.sv
logic/mem_wb_reg.sv
logic/write_back.sv
logic/reg_file.sv
logic/in_port.sv
logic/wb_top.sv
verification/wb_chk.sv
verification/wb_scoreboard.sv
verification/wb_tb.sv
